//--- Bender.yml
package:
  name: lf_envelope

sources:
  - rtl/lf_envelope_pkg.sv
  - rtl/beam_former.sv
  - rtl/beam_squarer.sv
  - rtl/sample_delay_line.sv
  - rtl/envelope_running_sum.sv
  - rtl/lf_envelope_top.sv
  - target: test
    files:
      - tests/lf_envelope_checker.sv
      - tests/lf_envelope_tb.sv

//--- rtl/beam_former.sv
`timescale 1ns/1ps

module beam_former import lf_envelope_pkg::*; (
    input  logic        clk_i,
    input  logic        sum_reset,
    input  chan_block_t chan_i,
    output half_block_t half_o
);

    // Plain sum of five 5-bit codes, at most 155, so 8 bits are enough
    logic [7:0] code_sum [NSAMP];

    // Doubled sum less the offset needs one extra bit before it is narrowed
    logic signed [HALF_W:0] half_wide [NSAMP];

    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            code_sum[s] = '0;
            for (int c = 0; c < NCHAN; c++) begin
                code_sum[s] = code_sum[s] + 8'(chan_i.code[s][c]);
            end
        end
    end

    // Working in half-units keeps the 0.5 per channel exact.
    // Dropping it instead would map all-31 to 77 and all-0 to -78,
    // and the two extremes would then square to different values
    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            half_wide[s] = $signed({1'b0, code_sum[s], 1'b0}) - (HALF_W + 1)'(CODE_OFFSET_HALF);
        end
    end

    // The result always lies in -155..155, so the top bit is only a sign copy
    always_ff @(posedge clk_i) begin
        if (sum_reset) begin
            // Park on the smallest odd value, whose corrected square is zero
            for (int s = 0; s < NSAMP; s++) begin
                half_o.samp[s] <= beam_half_t'(1);
            end
        end else begin
            for (int s = 0; s < NSAMP; s++) begin
                half_o.samp[s] <= half_wide[s][HALF_W-1:0];
            end
        end
    end

endmodule

//--- rtl/beam_squarer.sv
`timescale 1ns/1ps

module beam_squarer import lf_envelope_pkg::*; (
    input  logic          clk_i,
    input  logic          sum_reset,
    input  half_block_t   half_i,
    output square_block_t sq_o
);

    // Magnitude of a half-unit sample, at most 155
    logic [HALF_W-2:0] mag [NSAMP];

    // Stage one holds the raw square in quarter-units, at most 24025
    logic [2*(HALF_W-1)-1:0] sq_raw_q [NSAMP];

    // Raw square with the 0.25 term taken out, still in quarter-units
    logic [2*(HALF_W-1)-1:0] sq_corr [NSAMP];

    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            mag[s] = half_i.samp[s][HALF_W-1] ? (HALF_W-1)'(-half_i.samp[s])
                                              : (HALF_W-1)'(half_i.samp[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (sum_reset) begin
            // Matches the square of the value the beam former parks on
            for (int s = 0; s < NSAMP; s++) begin
                sq_raw_q[s] <= 1;
            end
        end else begin
            for (int s = 0; s < NSAMP; s++) begin
                sq_raw_q[s] <= mag[s] * mag[s];
            end
        end
    end

    // An odd square is 1 modulo 8, so after removing the 1 the two lowest
    // bits are zero and the shift by two is exact
    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            sq_corr[s] = sq_raw_q[s] - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sum_reset) begin
            sq_o <= '0;
        end else begin
            for (int s = 0; s < NSAMP; s++) begin
                sq_o.samp[s] <= sq_corr[s][2 +: SQUARE_W];
            end
        end
    end

endmodule

//--- rtl/envelope_running_sum.sv
`timescale 1ns/1ps

module envelope_running_sum import lf_envelope_pkg::*; #(
    parameter int unsigned SUM_DELAY = SUM_DELAY_DEF
) (
    input  logic           clk_i,
    input  logic           sum_reset,
    input  square_block_t  sq_a_i,
    input  square_block_t  sq_b_i,
    output envelope_pair_t env_o
);

    // The running sum is built as y[n] = y[n-1] + x[n] - x[n-SUM_DELAY],
    // where x is the four-sample sum of one block. The transfer function
    // (1 - z^-N) / (1 - z^-1) is a plain N-block boxcar, but the integrator
    // only stays correct if it starts from a consistent state, hence the
    // stretched clear below

    // Lane 0 carries beam A and lane 1 beam B
    square_block_t blk_q   [2];
    square_block_t blk_dly [2];
    beam_acc_t     diff_q  [2];
    beam_acc_t     acc_q   [2];

    // Clear stretcher state
    logic       rst_q;
    logic       reset_fall;
    clear_cnt_t clear_cnt;
    logic       clear;

    // Adds the four squares of one block, at most 24024
    function automatic beam_acc_t block_sum(input square_block_t blk);
        beam_acc_t total;
        total = '0;
        for (int s = 0; s < NSAMP; s++) begin
            total = total + beam_acc_t'(blk.samp[s]);
        end
        return total;
    endfunction

    // Falling edge of sum_reset, seen on the first cycle it is low
    assign reset_fall = rst_q && !sum_reset;

    // The fall cycle plus CLEAR_STRETCH-1 counted cycles give CLEAR_STRETCH
    // cycles of clear after sum_reset drops
    assign clear = sum_reset || reset_fall || (clear_cnt != '0);

    always_ff @(posedge clk_i) begin
        rst_q <= sum_reset;
        if (sum_reset) begin
            clear_cnt <= '0;
        end else if (reset_fall) begin
            clear_cnt <= clear_cnt_t'(CLEAR_STRETCH - 1);
        end else if (clear_cnt != '0) begin
            clear_cnt <= clear_cnt - 1'b1;
        end
    end

    // Input register. Zeros are loaded during the clear, and since the
    // clear outlasts the window the delay lines end up holding zeros too
    always_ff @(posedge clk_i) begin
        if (clear) begin
            blk_q[0] <= '0;
            blk_q[1] <= '0;
        end else begin
            blk_q[0] <= sq_a_i;
            blk_q[1] <= sq_b_i;
        end
    end

    // The delay lines tap the input register, so the subtracted block is
    // exactly the one that entered SUM_DELAY clocks before
    sample_delay_line #(
        .DEPTH (SUM_DELAY)
    ) u_dly_a (
        .clk_i  (clk_i),
        .din_i  (blk_q[0]),
        .dout_o (blk_dly[0])
    );

    sample_delay_line #(
        .DEPTH (SUM_DELAY)
    ) u_dly_b (
        .clk_i  (clk_i),
        .din_i  (blk_q[1]),
        .dout_o (blk_dly[1])
    );

    // Newest block in, oldest block out
    always_ff @(posedge clk_i) begin
        if (sum_reset) begin
            diff_q[0] <= '0;
            diff_q[1] <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                diff_q[b] <= block_sum(blk_q[b]) - block_sum(blk_dly[b]);
            end
        end
    end

    // Integrator, held at zero for the whole clear so env_o reads zero
    always_ff @(posedge clk_i) begin
        if (clear) begin
            acc_q[0] <= '0;
            acc_q[1] <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                acc_q[b] <= acc_q[b] + diff_q[b];
            end
        end
    end

    // The 48-sample sum needs 19 bits and is never negative once the
    // window is full, so the slice above OUTSHIFT is the envelope
    assign env_o.env_a = acc_q[0][OUTSHIFT +: ENV_W];
    assign env_o.env_b = acc_q[1][OUTSHIFT +: ENV_W];

endmodule

//--- rtl/lf_envelope_pkg.sv
package lf_envelope_pkg;

    // Block geometry: five channels are summed into each beam sample, four samples per clock
    localparam int NCHAN = 5;
    localparam int NSAMP = 4;

    // Running sum window in blocks, 12 blocks of 4 give 48 samples
    localparam int SUM_DELAY_DEF = 12;

    // The integrator stays cleared this many cycles after sum_reset falls.
    // It must be longer than the window so the delay lines flush to zero
    localparam int CLEAR_STRETCH = 16;

    // Final downshift of the 48-sample sum
    localparam int OUTSHIFT = 3;

    // Five codes, each offset by 15.5, give 77.5 or 155 in half-units
    localparam int CODE_OFFSET_HALF = 155;

    // 48 * 6006 = 288288, shifted down by 3
    localparam int ENV_MAX = 36036;

    // Vector widths
    localparam int CODE_W = 5;
    localparam int HALF_W = 9;
    localparam int SQUARE_W = 14;
    localparam int ACC_W = 24;
    localparam int ENV_W = 17;
    localparam int CLEAR_CNT_W = $clog2(CLEAR_STRETCH + 1);

    typedef logic [CODE_W-1:0] chan_code_t;
    // Odd by construction, from -155 to 155
    typedef logic signed [HALF_W-1:0] beam_half_t;
    // (x*x - 1) / 4 of a half-unit sample, at most 6006
    typedef logic [SQUARE_W-1:0] beam_square_t;
    typedef logic signed [ACC_W-1:0] beam_acc_t;
    typedef logic [ENV_W-1:0] envelope_t;
    typedef logic [CLEAR_CNT_W-1:0] clear_cnt_t;

    // One clock of channel codes for one beam, indexed [sample][channel]
    typedef struct packed {
        chan_code_t [NSAMP-1:0][NCHAN-1:0] code;
    } chan_block_t;

    typedef struct packed {
        beam_half_t [NSAMP-1:0] samp;
    } half_block_t;

    typedef struct packed {
        beam_square_t [NSAMP-1:0] samp;
    } square_block_t;

    typedef struct packed {
        envelope_t env_a;
        envelope_t env_b;
    } envelope_pair_t;

endpackage

//--- rtl/lf_envelope_top.sv
`timescale 1ns/1ps

module lf_envelope_top import lf_envelope_pkg::*; (
    input  logic           clk_i,
    input  logic           sum_reset,
    input  chan_block_t    chan_a_i,
    input  chan_block_t    chan_b_i,
    output envelope_pair_t env_o
);

    // Half-unit beam samples, one clock after the codes
    half_block_t half_a;
    half_block_t half_b;

    // Corrected squares, three clocks after the codes
    square_block_t sq_a;
    square_block_t sq_b;

    beam_former u_bf_a (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .chan_i    (chan_a_i),
        .half_o    (half_a)
    );

    beam_former u_bf_b (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .chan_i    (chan_b_i),
        .half_o    (half_b)
    );

    beam_squarer u_sq_a (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .half_i    (half_a),
        .sq_o      (sq_a)
    );

    beam_squarer u_sq_b (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .half_i    (half_b),
        .sq_o      (sq_b)
    );

    // Both beams share one running sum block and one clear stretcher
    envelope_running_sum #(
        .SUM_DELAY (SUM_DELAY_DEF)
    ) u_env (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .sq_a_i    (sq_a),
        .sq_b_i    (sq_b),
        .env_o     (env_o)
    );

endmodule

//--- rtl/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line import lf_envelope_pkg::*; #(
    parameter int unsigned DEPTH = SUM_DELAY_DEF
) (
    input  logic          clk_i,
    input  square_block_t din_i,
    output square_block_t dout_o
);

    // One tap per clock of delay, tap 0 is the newest block
    square_block_t taps [DEPTH];

    // Free-running shift register without reset or enable.
    // Whatever sits in it is flushed out after DEPTH clocks,
    // which the running sum relies on during its clear
    always_ff @(posedge clk_i) begin
        taps[0] <= din_i;
        for (int unsigned i = 1; i < DEPTH; i++) begin
            taps[i] <= taps[i-1];
        end
    end

    // The oldest tap is the input from DEPTH clocks ago
    assign dout_o = taps[DEPTH-1];

endmodule

//--- sim.f
rtl/lf_envelope_pkg.sv
rtl/beam_former.sv
rtl/beam_squarer.sv
rtl/sample_delay_line.sv
rtl/envelope_running_sum.sv
rtl/lf_envelope_top.sv
tests/lf_envelope_checker.sv
tests/lf_envelope_tb.sv

//--- tests/lf_envelope_checker.sv
`timescale 1ns/1ps

module lf_envelope_checker import lf_envelope_pkg::*; (
    input logic           clk_i,
    input logic           sum_reset,
    input envelope_pair_t env_i
);

    // Number of assertion failures seen so far
    int fail_count = 0;

    // Every reset cycle clears the integrator, so the next cycle reads zero
    a_zero_after_reset: assert property (@(posedge clk_i) sum_reset |=> (env_i == '0))
        else begin
            $error("env_o is not zero on the cycle after sum_reset was high");
            fail_count++;
        end

    // A full window of extreme samples gives ENV_MAX and nothing can exceed it
    a_env_in_range: assert property (@(posedge clk_i)
        !$isunknown(env_i) |-> (env_i.env_a <= ENV_MAX && env_i.env_b <= ENV_MAX))
        else begin
            $error("env_o is above the largest possible envelope");
            fail_count++;
        end

    // Once reset has been low for a cycle the whole pipeline holds known values
    a_env_known: assert property (@(posedge clk_i)
        (!sum_reset && $past(sum_reset) === 1'b0) |-> !$isunknown(env_i))
        else begin
            $error("env_o holds unknown bits after reset was released");
            fail_count++;
        end

endmodule

bind lf_envelope_top lf_envelope_checker u_chk (
    .clk_i     (clk_i),
    .sum_reset (sum_reset),
    .env_i     (env_o)
);

//--- tests/lf_envelope_tb.sv
`timescale 1ns/1ps

module lf_envelope_tb import lf_envelope_pkg::*; ();

    // Twelve blocks in the window plus the five newest still in the pipeline
    localparam int HIST_LEN = SUM_DELAY_DEF + 5;
    localparam int WAIT_LIMIT = 200;

    logic           clk_i;
    logic           sum_reset;
    chan_block_t    chan_a;
    chan_block_t    chan_b;
    envelope_pair_t env;

    logic [31:0] rng_state;
    int          edge_no;
    int          since_release;

    // Block sums per sampling edge, oldest first. A low ok flag marks a block
    // sampled so close to a clear that its contribution is not modelled
    int hist_a [$];
    int hist_b [$];
    bit hist_ok [$];

    lf_envelope_top dut_i (
        .clk_i     (clk_i),
        .sum_reset (sum_reset),
        .chan_a_i  (chan_a),
        .chan_b_i  (chan_b),
        .env_o     (env)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic chan_block_t fill_block(input int code);
        chan_block_t blk;
        for (int s = 0; s < NSAMP; s++) begin
            for (int c = 0; c < NCHAN; c++) begin
                blk.code[s][c] = chan_code_t'(code);
            end
        end
        return blk;
    endfunction

    // Half-unit value 2*sum-155 per sample, then (h*h-1)/4 summed over the block
    function automatic int block_square_sum(input chan_block_t blk);
        int code_total;
        int half;
        int total;
        total = 0;
        for (int s = 0; s < NSAMP; s++) begin
            code_total = 0;
            for (int c = 0; c < NCHAN; c++) begin
                code_total += int'(blk.code[s][c]);
            end
            half = 2 * code_total - CODE_OFFSET_HALF;
            total += (half * half - 1) / 4;
        end
        return total;
    endfunction

    function automatic bit window_full();
        if (hist_ok.size() < HIST_LEN) begin
            return 1'b0;
        end
        for (int i = 0; i < SUM_DELAY_DEF; i++) begin
            if (!hist_ok[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic random_block(output chan_block_t blk);
        for (int s = 0; s < NSAMP; s++) begin
            for (int c = 0; c < NCHAN; c++) begin
                rng_state = xorshift32(rng_state);
                blk.code[s][c] = rng_state[12:8];
            end
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
            else report_failure($sformatf("Error: %s expected %0d actual %0d",
                                          name, expected, actual));
    endtask

    // One clock: record the block sampled at the edge, check env_o just after
    // the edge, then drive the next inputs
    task automatic run_cycle(input string name, input logic rst,
                             input chan_block_t next_a, input chan_block_t next_b);
        int exp_a;
        int exp_b;
        @(posedge clk_i);
        edge_no++;
        since_release = sum_reset ? 0 : since_release + 1;
        hist_a.push_back(block_square_sum(chan_a));
        hist_b.push_back(block_square_sum(chan_b));
        hist_ok.push_back(!sum_reset && since_release > CLEAR_STRETCH);
        if (hist_ok.size() > HIST_LEN) begin
            void'(hist_a.pop_front());
            void'(hist_b.pop_front());
            void'(hist_ok.pop_front());
        end
        #1;
        assert (dut_i.u_chk.fail_count == 0)
            else report_failure("A bound assertion on the DUT failed");
        if (sum_reset || since_release <= CLEAR_STRETCH) begin
            check_value({name, " env_a during clear"}, 0, env.env_a);
            check_value({name, " env_b during clear"}, 0, env.env_b);
        end else if (window_full()) begin
            exp_a = 0;
            exp_b = 0;
            for (int i = 0; i < SUM_DELAY_DEF; i++) begin
                exp_a += hist_a[i];
                exp_b += hist_b[i];
            end
            check_value({name, " env_a"}, exp_a >> OUTSHIFT, env.env_a);
            check_value({name, " env_b"}, exp_b >> OUTSHIFT, env.env_b);
        end
        sum_reset = rst;
        chan_a = next_a;
        chan_b = next_b;
    endtask

    task automatic hold_inputs(input string name, input chan_block_t a, input chan_block_t b,
                               input int cycles);
        for (int i = 0; i < cycles; i++) begin
            run_cycle(name, 1'b0, a, b);
        end
    endtask

    task automatic run_random(input string name, input logic rst, input int cycles);
        chan_block_t ra;
        chan_block_t rb;
        for (int i = 0; i < cycles; i++) begin
            random_block(ra);
            random_block(rb);
            run_cycle(name, rst, ra, rb);
        end
    endtask

    // Reset for 8 cycles, then mid-scale codes until 20 cycles after release
    task automatic apply_reset(input string name);
        for (int i = 0; i < 8; i++) begin
            run_cycle(name, 1'b1, fill_block(15), fill_block(15));
        end
        hold_inputs(name, fill_block(15), fill_block(15), 20);
    endtask

    task automatic wait_full_window(input string name);
        int waited;
        waited = 0;
        while (!window_full()) begin
            assert (waited < WAIT_LIMIT)
                else report_failure($sformatf("Timeout in %s waiting for a full window", name));
            run_random(name, 1'b0, 1);
            waited++;
        end
    endtask

    // A lone block among zero-square blocks shows the exact window edges
    task automatic check_pulse(input string name, input bit on_b, input chan_block_t pulse);
        chan_block_t quiet;
        int start;
        int first;
        int last;
        int peak;
        int lane;
        for (int s = 0; s < NSAMP; s++) begin
            for (int c = 0; c < NCHAN; c++) begin
                // Codes summing to 77 give the half-unit value -1, square 0
                quiet.code[s][c] = (c < 3) ? 5'd15 : 5'd16;
            end
        end
        hold_inputs(name, quiet, quiet, HIST_LEN + 2);
        run_cycle(name, 1'b0, on_b ? quiet : pulse, on_b ? pulse : quiet);
        start = edge_no;
        first = -1;
        last = -1;
        peak = 0;
        for (int i = 0; i < HIST_LEN + 8; i++) begin
            run_cycle(name, 1'b0, quiet, quiet);
            lane = on_b ? env.env_b : env.env_a;
            check_value({name, " idle lane"}, 0, on_b ? env.env_a : env.env_b);
            if (lane != 0) begin
                if (first < 0) begin
                    first = edge_no - start;
                end
                last = edge_no - start;
                peak = lane;
            end
        end
        check_value({name, " first edge"}, 6, first);
        check_value({name, " last edge"}, 17, last);
        check_value({name, " pulse value"}, block_square_sum(pulse) >> OUTSHIFT, peak);
    endtask

    // Mid-scale code 15 is -2.5 per sample, corrected square 6
    task automatic midscale_settles();
        apply_reset("constant_midscale");
        hold_inputs("constant_midscale", fill_block(15), fill_block(15), HIST_LEN + 2);
        check_value("constant_midscale env_a", 36, env.env_a);
        check_value("constant_midscale env_b", 36, env.env_b);
    endtask

    // Both extremes must square to the same full-scale value
    task automatic extremes_match();
        apply_reset("symmetry");
        hold_inputs("symmetry", fill_block(31), fill_block(0), HIST_LEN + 2);
        check_value("symmetry env_a", ENV_MAX, env.env_a);
        check_value("symmetry env_b", ENV_MAX, env.env_b);
    endtask

    task automatic window_edges();
        apply_reset("window_length");
        check_pulse("window_length beam A", 1'b0, fill_block(31));
        check_pulse("window_length beam B", 1'b1, fill_block(0));
    endtask

    task automatic random_stream_matches();
        apply_reset("random_stream");
        wait_full_window("random_stream");
        run_random("random_stream", 1'b0, 200);
    endtask

    // Reset lands in the middle of a running stream that keeps going.
    // The model compares again once its window holds only blocks sampled
    // after the clear, which is CLEAR_STRETCH plus 18 cycles after release
    task automatic reset_mid_stream();
        apply_reset("reset_mid_stream");
        wait_full_window("reset_mid_stream");
        run_random("reset_mid_stream", 1'b0, 40);
        run_random("reset_mid_stream", 1'b1, 8);
        run_random("reset_mid_stream", 1'b0, CLEAR_STRETCH + 18 + 40);
    endtask

    initial begin
        sum_reset = 1'b1;
        chan_a = fill_block(15);
        chan_b = fill_block(15);
        rng_state = 32'he7c7;
        edge_no = 0;
        since_release = 0;

        midscale_settles();
        extremes_match();
        window_edges();
        random_stream_matches();
        reset_mid_stream();

        if (dut_i.u_chk.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("A bound assertion on the DUT failed");
        end
    end

endmodule
